//--- Makefile
# Verilator build and run for the board_top testbench

VERILATOR ?= verilator
TOP       ?= board_top_tb
FILELIST  ?= board_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
FAIL_MSG  ?= CHECKS FAILED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) board_settings.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- board_pkg.sv
// command opcode enum and state enums for receiver, engine and transmitter
package board_pkg;

  // values are the ASCII codes sent by the host
  typedef enum logic [7:0] {
    op_set_leds  = 8'h4C,
    op_add_leds  = 8'h41,
    op_read_leds = 8'h52,
    op_read_btns = 8'h42,
    // anything not listed above decodes to this
    op_unknown   = 8'h3F
  } cmd_op_e;

  typedef enum logic [1:0] {
    rx_st_idle,
    rx_st_start,
    rx_st_data,
    rx_st_stop
  } rx_state_e;

  typedef enum logic [1:0] {
    tx_st_idle,
    tx_st_start,
    tx_st_data,
    tx_st_stop
  } tx_state_e;

  typedef enum logic {
    eng_wait_opcode,
    eng_wait_operand
  } eng_state_e;

endpackage

//--- board_settings.svh
// serial bit timing, reset stretch length and board LED and button widths
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// 25 MHz / 115200 baud, rounded
`define CLKS_PER_BIT 217

// cycles the core reset stays high after the board reset falls
`define RESET_STRETCH 16

// ULX3S user LEDs
`define NUM_LEDS 8

// ULX3S push buttons, power button included
`define NUM_BTNS 7

`endif

//--- board_top.f
+incdir+.
board_pkg.sv
uart_rx.sv
cmd_engine.sv
uart_tx.sv
board_top.sv
board_top_chk.sv
board_top_tb.sv

//--- board_top.sv
// ULX3S board top with reset stretcher, uart receiver, command engine and uart transmitter
`timescale 1ns/1ns
`include "board_settings.svh"

module board_top (
  input  logic                 clk_25mhz,
  input  logic                 reset,
  input  logic [`NUM_BTNS-1:0] btns,
  input  logic                 ftdi_txd,
  output logic                 ftdi_rxd,
  output logic [`NUM_LEDS-1:0] leds
);

  logic [`RESET_STRETCH-1:0] rst_shift;
  logic                      core_reset;
  logic [7:0]                rx_data;
  logic                      rx_valid;
  logic [7:0]                tx_data;
  logic                      tx_start;

  // ones while reset is held, then drained one bit per cycle
  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      rst_shift <= '1;
    end else begin
      rst_shift <= rst_shift >> 1;
    end
  end

  assign core_reset = rst_shift[0];

  // ftdi_txd is the host's transmit line, so it feeds our receiver
  uart_rx i_rx (
    .clk_25mhz (clk_25mhz),
    .reset     (core_reset),
    .serial_in (ftdi_txd),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid)
  );

  cmd_engine i_engine (
    .clk_25mhz (clk_25mhz),
    .reset     (core_reset),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .btns      (btns),
    .leds      (leds),
    .tx_data   (tx_data),
    .tx_start  (tx_start)
  );

  uart_tx i_tx (
    .clk_25mhz  (clk_25mhz),
    .reset      (core_reset),
    .tx_data    (tx_data),
    .tx_start   (tx_start),
    .serial_out (ftdi_rxd)
  );

endmodule

//--- board_top_chk.sv
// concurrent assertions on reset stretching, serial idle level and single-cycle strobes
`timescale 1ns/1ns
`include "board_settings.svh"

module board_top_chk (
  input logic clk_25mhz,
  input logic reset,
  input logic core_reset,
  input logic ftdi_rxd,
  input logic rx_valid,
  input logic tx_start
);

  // cycles since the board reset was last sampled high, saturating
  int unsigned since_fall;

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      since_fall <= 0;
    end else if (since_fall < 1000) begin
      since_fall <= since_fall + 1;
    end
  end

  a_rxd_idle_in_reset: assert property (@(posedge clk_25mhz) disable iff (reset)
    core_reset |-> ftdi_rxd)
    else $error("ftdi_rxd low while the core reset is high");

  a_stretch_held: assert property (@(posedge clk_25mhz)
    (!reset && since_fall < `RESET_STRETCH) |-> core_reset)
    else $error("core reset released before the stretch ran out");

  a_stretch_released: assert property (@(posedge clk_25mhz)
    (!reset && since_fall == `RESET_STRETCH) |-> !core_reset)
    else $error("core reset still high after the stretch");

  a_rx_valid_single: assert property (@(posedge clk_25mhz) disable iff (core_reset)
    rx_valid |=> !rx_valid)
    else $error("rx_valid high in two consecutive cycles");

  a_tx_start_single: assert property (@(posedge clk_25mhz) disable iff (core_reset)
    tx_start |=> !tx_start)
    else $error("tx_start high in two consecutive cycles");

endmodule

bind board_top board_top_chk i_chk (
  .clk_25mhz  (clk_25mhz),
  .reset      (reset),
  .core_reset (core_reset),
  .ftdi_rxd   (ftdi_rxd),
  .rx_valid   (rx_valid),
  .tx_start   (tx_start)
);

//--- board_top_tb.sv
// directed testbench for board_top with serial driver, serial monitor and one task per test
`timescale 1ns/1ns
`include "board_settings.svh"

module board_top_tb;

  localparam int BIT_CYCLES   = `CLKS_PER_BIT;
  localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
  localparam int RX_TIMEOUT   = 3 * FRAME_CYCLES;
  localparam int DRIVE_DLY    = 2;
  localparam int BURST_LEN    = 5;
  // host command bytes, ASCII
  localparam logic [7:0] CMD_SET   = 8'h4C;
  localparam logic [7:0] CMD_ADD   = 8'h41;
  localparam logic [7:0] CMD_READ  = 8'h52;
  localparam logic [7:0] CMD_BTNS  = 8'h42;
  localparam logic [7:0] REPLY_BAD = 8'h3F;

  logic                 clk_25mhz = 1'b0;
  logic                 reset;
  logic [`NUM_BTNS-1:0] btns;
  logic                 ftdi_txd;
  logic                 ftdi_rxd;
  logic [`NUM_LEDS-1:0] leds;

  logic [31:0] lcg_state = 32'd30;
  logic [7:0]  led_model;
  int          error_count;
  int          test_count;
  int          failed_tests;

  board_top i_dut (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .btns      (btns),
    .ftdi_txd  (ftdi_txd),
    .ftdi_rxd  (ftdi_rxd),
    .leds      (leds)
  );

  always #20 clk_25mhz = ~clk_25mhz;

  function automatic logic [7:0] random_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic logic [7:0] random_unknown();
    logic [7:0] value;
    value = random_byte();
    while (value == CMD_SET || value == CMD_ADD || value == CMD_READ || value == CMD_BTNS) begin
      value = random_byte();
    end
    return value;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // 8N1 frame, each bit starts just after a rising edge
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_25mhz);
      #DRIVE_DLY;
      ftdi_txd = frame[i];
      repeat (BIT_CYCLES - 1) @(posedge clk_25mhz);
    end
  endtask

  // ftdi_rxd only moves on rising edges, so sample it on falling ones
  task automatic recv_byte(output logic [7:0] data, output logic ok);
    int waited;
    data = '0;
    ok = 1'b0;
    waited = 0;
    do begin
      @(negedge clk_25mhz);
      waited++;
    end while (ftdi_rxd !== 1'b0 && waited < RX_TIMEOUT);
    if (ftdi_rxd !== 1'b0) begin
      report_failure("no start bit on ftdi_rxd before the timeout");
      return;
    end
    repeat (BIT_CYCLES / 2) @(negedge clk_25mhz);
    if (ftdi_rxd !== 1'b0) begin
      report_failure("start bit on ftdi_rxd shorter than half a bit");
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CYCLES) @(negedge clk_25mhz);
      data[i] = ftdi_rxd;
    end
    repeat (BIT_CYCLES) @(negedge clk_25mhz);
    if (ftdi_rxd !== 1'b1) begin
      report_failure("stop bit on ftdi_rxd is low");
      return;
    end
    ok = 1'b1;
  endtask

  // the reply can start before the command's stop bit ends
  task automatic query(input logic [7:0] cmd, input logic [7:0] expected, input string what);
    logic [7:0] got;
    logic       ok;
    fork
      send_byte(cmd);
      recv_byte(got, ok);
    join
    if (ok && got !== expected) begin
      report_mismatch($sformatf("%s reply 0x%02h, expected 0x%02h", what, got, expected));
    end
  endtask

  task automatic check_leds(input string what);
    @(negedge clk_25mhz);
    if (leds !== led_model) begin
      report_mismatch($sformatf("%s: leds 0x%02h, expected 0x%02h", what, leds, led_model));
    end
  endtask

  task automatic test_reset_state();
    int err0;
    int idle_cycles;
    err0 = error_count;
    @(negedge clk_25mhz);
    if (leds !== 8'h00) begin
      report_mismatch($sformatf("leds 0x%02h after reset, expected 0x00", leds));
    end
    idle_cycles = 0;
    while (idle_cycles < RX_TIMEOUT) begin
      @(negedge clk_25mhz);
      if (ftdi_rxd !== 1'b1) begin
        report_failure("ftdi_rxd left the idle level with no command sent");
        break;
      end
      idle_cycles++;
    end
    finish_test("reset_state", err0);
  endtask

  task automatic test_set_read();
    int err0;
    err0 = error_count;
    led_model = random_byte();
    send_byte(CMD_SET);
    send_byte(led_model);
    check_leds("set");
    query(CMD_READ, led_model, "read after set");
    finish_test("set_read", err0);
  endtask

  task automatic test_add_wrap();
    int         err0;
    logic [7:0] a;
    logic [7:0] b;
    err0 = error_count;
    for (int round = 0; round < 2; round++) begin
      a = random_byte();
      b = random_byte();
      // second round always carries out of bit 7
      if (round == 1) begin
        a[7] = 1'b1;
        b[7] = 1'b1;
      end
      send_byte(CMD_SET);
      send_byte(a);
      send_byte(CMD_ADD);
      send_byte(b);
      led_model = a + b;
      check_leds("add");
      query(CMD_READ, led_model, "read after add");
    end
    finish_test("add_wrap", err0);
  endtask

  task automatic test_read_btns();
    int         err0;
    logic [7:0] value;
    err0 = error_count;
    value = random_byte();
    @(posedge clk_25mhz);
    #DRIVE_DLY;
    btns = value[6:0];
    query(CMD_BTNS, {1'b0, value[6:0]}, "button read");
    finish_test("read_btns", err0);
  endtask

  task automatic test_unknown_burst();
    int         err0;
    int         received;
    logic [7:0] got;
    logic       ok;
    err0 = error_count;
    received = 0;
    // replies overlap the next command, so the holding buffer gets used
    fork
      begin
        for (int i = 0; i < BURST_LEN; i++) begin
          send_byte(random_unknown());
        end
      end
      begin
        for (int i = 0; i < BURST_LEN; i++) begin
          recv_byte(got, ok);
          if (!ok) break;
          received++;
          if (got !== REPLY_BAD) begin
            report_mismatch($sformatf("reply %0d to unknown byte is 0x%02h, expected 0x3f",
                                      i, got));
          end
        end
      end
    join
    if (received != BURST_LEN) begin
      report_failure($sformatf("only %0d of %0d replies to unknown bytes arrived",
                               received, BURST_LEN));
    end
    query(CMD_READ, led_model, "read after unknown burst");
    finish_test("unknown_burst", err0);
  endtask

  initial begin
    reset = 1'b1;
    ftdi_txd = 1'b1;
    btns = '0;
    led_model = '0;
    error_count = 0;
    test_count = 0;
    failed_tests = 0;
    repeat (10) @(posedge clk_25mhz);
    #DRIVE_DLY;
    reset = 1'b0;
    // core logic leaves reset RESET_STRETCH cycles later
    repeat (`RESET_STRETCH + 2) @(posedge clk_25mhz);
    test_reset_state();
    test_set_read();
    test_add_wrap();
    test_read_btns();
    test_unknown_burst();
    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- cmd_engine.sv
// command parser and executor with LED register, button synchronizer and reply bytes
`timescale 1ns/1ns
`include "board_settings.svh"

module cmd_engine
  import board_pkg::*;
(
  input  logic                 clk_25mhz,
  input  logic                 reset,
  input  logic [7:0]           rx_data,
  input  logic                 rx_valid,
  input  logic [`NUM_BTNS-1:0] btns,
  output logic [`NUM_LEDS-1:0] leds,
  output logic [7:0]           tx_data,
  output logic                 tx_start
);

  eng_state_e           state;
  cmd_op_e              pending_op;
  cmd_op_e              rx_op;
  logic [`NUM_BTNS-1:0] btn_meta;
  logic [`NUM_BTNS-1:0] btn_sync;

  function automatic cmd_op_e decode_op(input logic [7:0] code);
    cmd_op_e op;
    case (code)
      op_set_leds:  op = op_set_leds;
      op_add_leds:  op = op_add_leds;
      op_read_leds: op = op_read_leds;
      op_read_btns: op = op_read_btns;
      default:      op = op_unknown;
    endcase
    return op;
  endfunction

  assign rx_op = decode_op(rx_data);

  // buttons are asynchronous to the board clock
  always_ff @(posedge clk_25mhz) begin
    btn_meta <= btns;
    btn_sync <= btn_meta;
  end

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      state      <= eng_wait_opcode;
      pending_op <= op_set_leds;
      leds       <= '0;
      tx_start   <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      if (rx_valid) begin
        case (state)
          eng_wait_opcode: begin
            case (rx_op)
              op_set_leds, op_add_leds: begin
                pending_op <= rx_op;
                state      <= eng_wait_operand;
              end
              // reads and unknown bytes all answer with one byte
              default: tx_start <= 1'b1;
            endcase
          end
          eng_wait_operand: begin
            if (pending_op == op_add_leds) begin
              // wraps modulo 256
              leds <= leds + rx_data;
            end else begin
              leds <= rx_data;
            end
            state <= eng_wait_opcode;
          end
          default: state <= eng_wait_opcode;
        endcase
      end
    end
  end

  // reply byte, loaded in the same cycle tx_start is raised
  always_ff @(posedge clk_25mhz) begin
    if (rx_valid && state == eng_wait_opcode) begin
      case (rx_op)
        op_read_leds: tx_data <= 8'(leds);
        // top bit stays zero with seven buttons
        op_read_btns: tx_data <= 8'(btn_sync);
        op_unknown:   tx_data <= 8'h3F;
        default: ;
      endcase
    end
  end

endmodule

//--- uart_rx.sv
// 8N1 uart receiver with line synchronizer, mid-bit sampling and stop-bit check
`timescale 1ns/1ns
`include "board_settings.svh"

module uart_rx
  import board_pkg::*;
(
  input  logic       clk_25mhz,
  input  logic       reset,
  input  logic       serial_in,
  output logic [7:0] rx_data,
  output logic       rx_valid
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`CLKS_PER_BIT / 2 - 1);

  rx_state_e        state;
  logic [1:0]       line_sync;
  logic             line_prev;
  logic             line;
  logic             start_edge;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_reg;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      line_sync <= 2'b11;
      line_prev <= 1'b1;
    end else begin
      line_sync <= {line_sync[0], serial_in};
      line_prev <= line_sync[1];
    end
  end

  assign line       = line_sync[1];
  assign start_edge = line_prev & ~line;

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      state    <= rx_st_idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        rx_st_idle: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (start_edge) begin
            state <= rx_st_start;
          end
        end
        rx_st_start: begin
          if (cnt == HALF_LAST) begin
            cnt <= '0;
            // a pulse shorter than half a bit is noise
            state <= line ? rx_st_idle : rx_st_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_st_data: begin
          if (cnt == BIT_LAST) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= rx_st_stop;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_st_stop: begin
          if (cnt == BIT_LAST) begin
            cnt <= '0;
            // framing error drops the byte silently
            rx_valid <= line;
            state    <= rx_st_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= rx_st_idle;
      endcase
    end
  end

  // lsb arrives first, so shift in from the top
  always_ff @(posedge clk_25mhz) begin
    if (state == rx_st_data && cnt == BIT_LAST) begin
      shift_reg <= {line, shift_reg[7:1]};
    end
  end

  assign rx_data = shift_reg;

endmodule

//--- uart_tx.sv
// 8N1 uart transmitter with a one-byte holding buffer
`timescale 1ns/1ns
`include "board_settings.svh"

module uart_tx
  import board_pkg::*;
(
  input  logic       clk_25mhz,
  input  logic       reset,
  input  logic [7:0] tx_data,
  input  logic       tx_start,
  output logic       serial_out
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

  tx_state_e        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_reg;
  logic [7:0]       hold_data;
  logic             hold_full;
  logic             bit_done;

  assign bit_done = (cnt == BIT_LAST);

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      state      <= tx_st_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      hold_full  <= 1'b0;
      serial_out <= 1'b1;
    end else begin
      cnt <= (state == tx_st_idle || bit_done) ? '0 : cnt + 1'b1;
      case (state)
        tx_st_idle: begin
          bit_idx <= '0;
          if (hold_full) begin
            shift_reg  <= hold_data;
            hold_full  <= 1'b0;
            serial_out <= 1'b0;
            state      <= tx_st_start;
          end else if (tx_start) begin
            shift_reg  <= tx_data;
            serial_out <= 1'b0;
            state      <= tx_st_start;
          end
        end
        tx_st_start: begin
          if (bit_done) begin
            serial_out <= shift_reg[0];
            state      <= tx_st_data;
          end
        end
        tx_st_data: begin
          if (bit_done) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              serial_out <= 1'b1;
              state      <= tx_st_stop;
            end else begin
              serial_out <= shift_reg[1];
              shift_reg  <= {1'b0, shift_reg[7:1]};
            end
          end
        end
        tx_st_stop: begin
          if (bit_done) begin
            bit_idx <= '0;
            // buffered byte follows straight after the stop bit
            if (hold_full) begin
              shift_reg  <= hold_data;
              hold_full  <= 1'b0;
              serial_out <= 1'b0;
              state      <= tx_st_start;
            end else begin
              state <= tx_st_idle;
            end
          end
        end
        default: state <= tx_st_idle;
      endcase
      // strobe during a frame goes to the holding buffer
      if (tx_start && (state != tx_st_idle || hold_full)) begin
        hold_data <= tx_data;
        hold_full <= 1'b1;
      end
    end
  end

endmodule
